/* hdl/rv_settings.svh */
// rv64i decode stage widths fixed by the isa
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// register and pc width
`define RV_XLEN 64

// raw instruction word
`define RV_INST_W 32

// register index width and register count
`define RV_REG_AW 5
`define RV_NUM_REGS 32

`endif

/* hdl/rv_pkg.sv */
// rv64i decode stage shared vector types and control encodings
`include "rv_settings.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]   xlen_t;     // data, imm, pc
  typedef logic [`RV_INST_W-1:0] inst_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // operation handed to the execute stage
  typedef enum logic [1:0] {
    ALU_ADD      = 2'd0,
    ALU_SUB      = 2'd1,
    ALU_PASS_IMM = 2'd2,  // lui
    ALU_LINK     = 2'd3   // pc + 4 for jal
  } alu_op_e;

  // branch kind evaluated in decode
  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_EQ   = 2'd1,
    BR_NE   = 2'd2,
    BR_JAL  = 2'd3
  } br_func_e;

endpackage

/* hdl/rv_decoder.sv */
// combinational instruction decoder for the lui, jal, beq, bne, addi, add, sub and ebreak subset
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decoder (
  input  rv_pkg::inst_t     i_inst,
  output rv_pkg::reg_addr_t o_rs1,
  output rv_pkg::reg_addr_t o_rs2,
  output rv_pkg::reg_addr_t o_rd,
  output rv_pkg::xlen_t     o_imm,
  output rv_pkg::alu_op_e   o_alu_op,
  output rv_pkg::br_func_e  o_br_func,
  output logic              o_gpr_wen,
  output logic              o_invalid
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam rv_pkg::inst_t EBREAK_INST = 32'h0010_0073;

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  rv_pkg::xlen_t imm_i;
  rv_pkg::xlen_t imm_b;
  rv_pkg::xlen_t imm_u;
  rv_pkg::xlen_t imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // sign extended immediates
  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_b = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    // defaults describe an invalid instruction
    o_rs1     = '0;
    o_rs2     = '0;
    o_rd      = '0;
    o_imm     = '0;
    o_alu_op  = rv_pkg::ALU_ADD;
    o_br_func = rv_pkg::BR_NONE;
    o_gpr_wen = 1'b0;
    o_invalid = 1'b1;
    case (opcode)
      OPC_LUI: begin
        o_rd      = i_inst[11:7];
        o_imm     = imm_u;
        o_alu_op  = rv_pkg::ALU_PASS_IMM;
        o_gpr_wen = 1'b1;
        o_invalid = 1'b0;
      end
      OPC_JAL: begin
        o_rd      = i_inst[11:7];
        o_imm     = imm_j;
        o_alu_op  = rv_pkg::ALU_LINK;
        o_br_func = rv_pkg::BR_JAL;
        o_gpr_wen = 1'b1;
        o_invalid = 1'b0;
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          o_rs1     = i_inst[19:15];
          o_rs2     = i_inst[24:20];
          o_imm     = imm_b;
          o_br_func = funct3[0] ? rv_pkg::BR_NE : rv_pkg::BR_EQ;
          o_invalid = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin  // addi only
          o_rs1     = i_inst[19:15];
          o_rd      = i_inst[11:7];
          o_imm     = imm_i;
          o_gpr_wen = 1'b1;
          o_invalid = 1'b0;
        end
      end
      OPC_OP: begin
        if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
          o_rs1     = i_inst[19:15];
          o_rs2     = i_inst[24:20];
          o_rd      = i_inst[11:7];
          o_alu_op  = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          o_gpr_wen = 1'b1;
          o_invalid = 1'b0;
        end
      end
      default: begin
        if (i_inst == EBREAK_INST) begin
          o_rs1     = 5'd10;  // a0 carries the exit code
          o_invalid = 1'b0;
        end
      end
    endcase
  end

endmodule

/* hdl/rv_gpr_file.sv */
// 32 x xlen register file with two async reads, one sync write and x0 tied to zero
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_gpr_file (
  input  logic              i_clk,
  input  rv_pkg::reg_addr_t i_raddr1,
  input  rv_pkg::reg_addr_t i_raddr2,
  input  logic              i_wen,
  input  rv_pkg::reg_addr_t i_waddr,
  input  rv_pkg::xlen_t     i_wdata,
  output rv_pkg::xlen_t     o_rdata1,
  output rv_pkg::xlen_t     o_rdata2
);

  rv_pkg::xlen_t regs [`RV_NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // a write shows on port 1 from the next cycle and x0 stays zero
  a_write_lands: assert property (@(posedge i_clk)
    (i_wen && i_raddr1 == i_waddr)
      |=> (i_raddr1 != $past(i_waddr))
          || (o_rdata1 == ($past(i_waddr) == '0 ? '0 : $past(i_wdata))));

endmodule

/* hdl/rv_hazard_check.sv */
// raw interlock against destinations still in execute, memory and writeback
`timescale 1ns/1ps

module rv_hazard_check (
  input  rv_pkg::reg_addr_t i_rs1,
  input  rv_pkg::reg_addr_t i_rs2,
  input  rv_pkg::reg_addr_t i_es_rd,
  input  rv_pkg::reg_addr_t i_ms_rd,
  input  rv_pkg::reg_addr_t i_ws_rd,
  output logic              o_stall
);

  logic rs1_hit;
  logic rs2_hit;

  // zero means no pending write
  function automatic logic src_hit(input rv_pkg::reg_addr_t src,
                                   input rv_pkg::reg_addr_t es_rd,
                                   input rv_pkg::reg_addr_t ms_rd,
                                   input rv_pkg::reg_addr_t ws_rd);
    logic hit;
    hit = (src != '0) && ((src == es_rd) || (src == ms_rd) || (src == ws_rd));
    return hit;
  endfunction

  assign rs1_hit = src_hit(i_rs1, i_es_rd, i_ms_rd, i_ws_rd);
  assign rs2_hit = src_hit(i_rs2, i_es_rd, i_ms_rd, i_ws_rd);
  assign o_stall = rs1_hit || rs2_hit;

endmodule

/* hdl/rv_branch_unit.sv */
// branch unit evaluating beq/bne/jal conditions and the pc relative redirect target
`timescale 1ns/1ps

module rv_branch_unit (
  input  rv_pkg::br_func_e i_br_func,
  input  rv_pkg::xlen_t    i_rs1_data,
  input  rv_pkg::xlen_t    i_rs2_data,
  input  rv_pkg::xlen_t    i_pc,
  input  rv_pkg::xlen_t    i_imm,
  output logic             o_cond,
  output rv_pkg::xlen_t    o_target
);

  logic src_eq;

  assign src_eq = (i_rs1_data == i_rs2_data);

  always_comb begin
    case (i_br_func)
      rv_pkg::BR_EQ:  o_cond = src_eq;
      rv_pkg::BR_NE:  o_cond = !src_eq;
      rv_pkg::BR_JAL: o_cond = 1'b1;  // unconditional
      default:        o_cond = 1'b0;
    endcase
  end

  // both b-type and j-type are pc relative
  assign o_target = i_pc + i_imm;

endmodule

/* hdl/rv_id_stage.sv */
// rv64i decode stage top with valid/allowin handshake, operand read, interlock and redirect
`timescale 1ns/1ps

module rv_id_stage (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_es_allowin,
  output logic              o_ds_allowin,
  input  logic              i_fs_valid,
  input  rv_pkg::inst_t     i_fs_inst,
  input  rv_pkg::xlen_t     i_fs_pc,
  output logic              o_es_valid,
  output rv_pkg::xlen_t     o_es_pc,
  output rv_pkg::xlen_t     o_es_rs1_data,
  output rv_pkg::xlen_t     o_es_rs2_data,
  output rv_pkg::xlen_t     o_es_imm,
  output rv_pkg::alu_op_e   o_es_alu_op,
  output rv_pkg::reg_addr_t o_es_rd,
  output logic              o_es_gpr_wen,
  output logic              o_es_invalid,
  output logic              o_br_taken,
  output rv_pkg::xlen_t     o_br_target,
  input  logic              i_ws_wen,
  input  rv_pkg::reg_addr_t i_ws_waddr,
  input  rv_pkg::xlen_t     i_ws_wdata,
  input  rv_pkg::reg_addr_t i_es_rd,
  input  rv_pkg::reg_addr_t i_ms_rd,
  input  rv_pkg::reg_addr_t i_ws_rd
);

  logic              ds_valid;
  logic              ds_stall;
  logic              ds_ready_go;
  rv_pkg::inst_t     ds_inst;
  rv_pkg::xlen_t     ds_pc;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::br_func_e  br_func;
  logic              br_cond;

  assign ds_ready_go  = !ds_stall;
  assign o_ds_allowin = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_es_valid   = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;  // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  assign o_es_pc = ds_pc;

  rv_decoder u_decoder (
    .i_inst    (ds_inst),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_rd      (o_es_rd),
    .o_imm     (o_es_imm),
    .o_alu_op  (o_es_alu_op),
    .o_br_func (br_func),
    .o_gpr_wen (o_es_gpr_wen),
    .o_invalid (o_es_invalid)
  );

  rv_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_wen),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata),
    .o_rdata1 (o_es_rs1_data),
    .o_rdata2 (o_es_rs2_data)
  );

  rv_hazard_check u_hazard_check (
    .i_rs1   (rs1),
    .i_rs2   (rs2),
    .i_es_rd (i_es_rd),
    .i_ms_rd (i_ms_rd),
    .i_ws_rd (i_ws_rd),
    .o_stall (ds_stall)
  );

  rv_branch_unit u_branch_unit (
    .i_br_func  (br_func),
    .i_rs1_data (o_es_rs1_data),
    .i_rs2_data (o_es_rs2_data),
    .i_pc       (ds_pc),
    .i_imm      (o_es_imm),
    .o_cond     (br_cond),
    .o_target   (o_br_target)
  );

  assign o_br_taken = o_es_valid && br_cond;  // only for a presented instruction

  // held instruction keeps its decoded bundle and operands under back-pressure
  a_bundle_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_es_valid && !i_es_allowin)
      |=> ds_valid && $stable(o_es_pc) && $stable(o_es_imm) && $stable(o_es_alu_op)
          && $stable(o_es_rd) && $stable(o_es_gpr_wen) && $stable(o_es_invalid)
          && $stable(o_es_rs1_data) && $stable(o_es_rs2_data));

  // redirect only from a presented, decodable instruction
  a_br_valid: assert property (@(posedge i_clk) disable iff (i_reset)
    o_br_taken |-> o_es_valid && !o_es_invalid);

endmodule

/* tb/tb_id_stage.sv */
// table driven testbench for the rv64i decode stage against a shadow register file
`timescale 1ns/1ps

module tb_id_stage;

  typedef struct {
    string             name;
    rv_pkg::inst_t     inst;
    rv_pkg::xlen_t     pc;
    rv_pkg::reg_addr_t es_rd;
    rv_pkg::reg_addr_t ms_rd;
    rv_pkg::reg_addr_t ws_rd;
    int                haz_cycles;
    logic              wb_en;
    rv_pkg::reg_addr_t wb_addr;
    rv_pkg::xlen_t     wb_data;
    int                bp_cycles;
    rv_pkg::reg_addr_t src1;     // register whose value should appear as rs1 data
    rv_pkg::reg_addr_t src2;
    rv_pkg::reg_addr_t exp_rd;
    rv_pkg::xlen_t     exp_imm;
    rv_pkg::alu_op_e   exp_alu;
    logic              exp_wen;
    logic              exp_inv;
    int                br_kind;  // 0 none, 1 eq, 2 ne, 3 jal
  } row_t;

  logic              i_clk;
  logic              i_reset;
  logic              i_es_allowin;
  logic              o_ds_allowin;
  logic              i_fs_valid;
  rv_pkg::inst_t     i_fs_inst;
  rv_pkg::xlen_t     i_fs_pc;
  logic              o_es_valid;
  rv_pkg::xlen_t     o_es_pc;
  rv_pkg::xlen_t     o_es_rs1_data;
  rv_pkg::xlen_t     o_es_rs2_data;
  rv_pkg::xlen_t     o_es_imm;
  rv_pkg::alu_op_e   o_es_alu_op;
  rv_pkg::reg_addr_t o_es_rd;
  logic              o_es_gpr_wen;
  logic              o_es_invalid;
  logic              o_br_taken;
  rv_pkg::xlen_t     o_br_target;
  logic              i_ws_wen;
  rv_pkg::reg_addr_t i_ws_waddr;
  rv_pkg::xlen_t     i_ws_wdata;
  rv_pkg::reg_addr_t i_es_rd;
  rv_pkg::reg_addr_t i_ms_rd;
  rv_pkg::reg_addr_t i_ws_rd;

  rv_pkg::xlen_t shadow [32];
  row_t          rows [$];
  int            row_errs;
  int            total_errs;
  int            failed_tests;
  int            num_tests;

  rv_id_stage DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic expect_true(input logic ok, input string msg);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, msg);
      row_errs++;
    end
  endtask

  task automatic report_test(input string name);
    num_tests++;
    total_errs += row_errs;
    if (row_errs != 0) failed_tests++;
    $display("test %0d %s: %s (%0d errors)", num_tests, name,
             (row_errs == 0) ? "ok" : "FAILED", row_errs);
    row_errs = 0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while (!o_ds_allowin && n < 50);
    if (!o_ds_allowin) begin
      $display("timeout: decode stage never raised allowin within 50 cycles");
      $display("sim failed");
      $finish;
    end
  endtask

  task automatic wait_presented();
    int n;
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while (!o_es_valid && n < 50);
    if (!o_es_valid) begin
      $display("timeout: instruction never presented to execute within 50 cycles");
      $display("sim failed");
      $finish;
    end
  endtask

  task automatic add_row(input string name, input rv_pkg::inst_t inst, input rv_pkg::xlen_t pc,
                         input rv_pkg::reg_addr_t es_rd, input rv_pkg::reg_addr_t ms_rd,
                         input rv_pkg::reg_addr_t ws_rd, input int haz_cycles,
                         input logic wb_en, input rv_pkg::reg_addr_t wb_addr,
                         input rv_pkg::xlen_t wb_data, input int bp_cycles,
                         input rv_pkg::reg_addr_t src1, input rv_pkg::reg_addr_t src2,
                         input rv_pkg::reg_addr_t exp_rd, input rv_pkg::xlen_t exp_imm,
                         input rv_pkg::alu_op_e exp_alu, input logic exp_wen,
                         input logic exp_inv, input int br_kind);
    row_t r;
    r = '{name, inst, pc, es_rd, ms_rd, ws_rd, haz_cycles, wb_en, wb_addr, wb_data,
          bp_cycles, src1, src2, exp_rd, exp_imm, exp_alu, exp_wen, exp_inv, br_kind};
    rows.push_back(r);
  endtask

  task automatic run_row(input row_t r);
    logic          exp_taken;
    rv_pkg::xlen_t held_pc;
    rv_pkg::xlen_t held_imm;
    wait_ready();
    i_fs_valid   = 1'b1;
    i_fs_inst    = r.inst;
    i_fs_pc      = r.pc;
    i_es_rd      = r.es_rd;
    i_ms_rd      = r.ms_rd;
    i_ws_rd      = r.ws_rd;
    i_es_allowin = 1'b0;  // hold the stage while it is checked
    @(negedge i_clk);
    i_fs_valid = 1'b0;
    if (r.haz_cycles == 0) expect_true(o_es_valid, "not presented the cycle after transfer");
    for (int k = 0; k < r.haz_cycles; k++) begin
      @(negedge i_clk);
      expect_true(!o_es_valid, "o_es_valid high during interlock");
      if (k == r.haz_cycles - 1 && r.wb_en) begin
        i_ws_wen   = 1'b1;
        i_ws_waddr = r.wb_addr;
        i_ws_wdata = r.wb_data;
      end
    end
    if (r.haz_cycles > 0) begin
      @(negedge i_clk);
      i_ws_wen = 1'b0;
      i_es_rd  = '0;
      i_ms_rd  = '0;
      i_ws_rd  = '0;
      if (r.wb_en && r.wb_addr != '0) shadow[r.wb_addr] = r.wb_data;
    end
    wait_presented();
    case (r.br_kind)
      1:       exp_taken = (shadow[r.src1] == shadow[r.src2]);
      2:       exp_taken = (shadow[r.src1] != shadow[r.src2]);
      3:       exp_taken = 1'b1;
      default: exp_taken = 1'b0;
    endcase
    expect_true(o_es_pc == r.pc, "wrong o_es_pc");
    expect_true(o_es_rd == r.exp_rd, "wrong o_es_rd");
    expect_true(o_es_imm == r.exp_imm, "wrong o_es_imm");
    expect_true(o_es_alu_op == r.exp_alu, "wrong o_es_alu_op");
    expect_true(o_es_gpr_wen == r.exp_wen, "wrong o_es_gpr_wen");
    expect_true(o_es_invalid == r.exp_inv, "wrong o_es_invalid");
    expect_true(o_es_rs1_data == shadow[r.src1], "wrong rs1 data");
    expect_true(o_es_rs2_data == shadow[r.src2], "wrong rs2 data");
    expect_true(o_br_taken == exp_taken, "wrong o_br_taken");
    if (r.br_kind != 0) expect_true(o_br_target == r.pc + r.exp_imm, "wrong o_br_target");
    held_pc  = o_es_pc;
    held_imm = o_es_imm;
    for (int k = 0; k < r.bp_cycles; k++) begin
      @(negedge i_clk);
      expect_true(o_es_valid && !o_ds_allowin, "handshake moved under back-pressure");
      expect_true(o_es_pc == held_pc && o_es_imm == held_imm, "bundle changed while held");
    end
    i_es_allowin = 1'b1;
    i_es_rd      = '0;
    i_ms_rd      = '0;
    i_ws_rd      = '0;
    @(negedge i_clk);
    expect_true(!o_es_valid && o_ds_allowin, "stage not empty after release");
  endtask

  initial begin
    void'($urandom(23452));
    i_reset      = 1'b1;
    i_es_allowin = 1'b1;
    i_fs_valid   = 1'b0;
    i_fs_inst    = '0;
    i_fs_pc      = '0;
    i_ws_wen     = 1'b0;
    i_ws_waddr   = '0;
    i_ws_wdata   = '0;
    i_es_rd      = '0;
    i_ms_rd      = '0;
    i_ws_rd      = '0;
    row_errs     = 0;
    total_errs   = 0;
    failed_tests = 0;
    num_tests    = 0;
    shadow[0]    = '0;
    repeat (2) @(negedge i_clk);
    i_reset = 1'b0;
    @(negedge i_clk);
    expect_true(!o_es_valid && !o_br_taken && o_ds_allowin, "bad state after reset");
    report_test("reset");

    // random fill of x1..x31 through the writeback port
    for (int r = 1; r < 32; r++) begin
      i_ws_wen   = 1'b1;
      i_ws_waddr = rv_pkg::reg_addr_t'(r);
      i_ws_wdata = {$urandom, $urandom};
      shadow[r]  = i_ws_wdata;
      @(negedge i_clk);
    end
    i_ws_wen = 1'b0;

    add_row("addi neg imm, rs2 field ignored", 32'hFFD08293, 64'h100, 0, 29, 0, 0, 0, 0, 0, 0,
            1, 0, 5, 64'hFFFF_FFFF_FFFF_FFFD, rv_pkg::ALU_ADD, 1, 0, 0);
    add_row("add", 32'h00310333, 64'h104, 0, 0, 0, 0, 0, 0, 0, 0,
            2, 3, 6, 64'h0, rv_pkg::ALU_ADD, 1, 0, 0);
    add_row("sub with x0", 32'h400203B3, 64'h108, 0, 0, 0, 0, 0, 0, 0, 0,
            4, 0, 7, 64'h0, rv_pkg::ALU_SUB, 1, 0, 0);
    add_row("lui", 32'h80000437, 64'h10C, 0, 0, 0, 0, 0, 0, 0, 0,
            0, 0, 8, 64'hFFFF_FFFF_8000_0000, rv_pkg::ALU_PASS_IMM, 1, 0, 0);
    add_row("addi stall on es", 32'h00558493, 64'h110, 11, 0, 0, 3, 1, 11, 64'h1234, 0,
            11, 0, 9, 64'h5, rv_pkg::ALU_ADD, 1, 0, 0);
    add_row("add stall on ws", 32'h00E68633, 64'h114, 0, 0, 14, 2, 1, 14, 64'hABC, 0,
            13, 14, 12, 64'h0, rv_pkg::ALU_ADD, 1, 0, 0);
    add_row("beq taken", 32'h00108863, 64'h1000, 0, 0, 0, 0, 0, 0, 0, 0,
            1, 1, 0, 64'h10, rv_pkg::ALU_ADD, 0, 0, 1);
    add_row("beq x1 x2", 32'h00208863, 64'h1004, 0, 0, 0, 0, 0, 0, 0, 0,
            1, 2, 0, 64'h10, rv_pkg::ALU_ADD, 0, 0, 1);
    add_row("bne back", 32'hFE209CE3, 64'h1008, 0, 0, 0, 0, 0, 0, 0, 0,
            1, 2, 0, 64'hFFFF_FFFF_FFFF_FFF8, rv_pkg::ALU_ADD, 0, 0, 2);
    add_row("jal", 32'h001000EF, 64'h100C, 0, 1, 0, 0, 0, 0, 0, 0,
            0, 0, 1, 64'h800, rv_pkg::ALU_LINK, 1, 0, 3);
    add_row("add back-pressure", 32'h00310333, 64'h1010, 0, 0, 0, 0, 0, 0, 0, 4,
            2, 3, 6, 64'h0, rv_pkg::ALU_ADD, 1, 0, 0);
    add_row("andi invalid", 32'h00007013, 64'h1014, 0, 0, 0, 0, 0, 0, 0, 0,
            0, 0, 0, 64'h0, rv_pkg::ALU_ADD, 0, 1, 0);
    add_row("ebreak stall on a0", 32'h00100073, 64'h1018, 0, 10, 0, 2, 1, 10, 64'h5A5A, 0,
            10, 0, 0, 64'h0, rv_pkg::ALU_ADD, 0, 0, 0);
    add_row("ebreak", 32'h00100073, 64'h101C, 0, 0, 0, 0, 0, 0, 0, 0,
            10, 0, 0, 64'h0, rv_pkg::ALU_ADD, 0, 0, 0);

    foreach (rows[i]) begin
      run_row(rows[i]);
      report_test(rows[i].name);
    end

    // second instruction waits behind a held one
    wait_ready();
    i_fs_valid   = 1'b1;
    i_fs_inst    = 32'h00310333;
    i_fs_pc      = 64'h2000;
    i_es_allowin = 1'b0;
    @(negedge i_clk);
    i_fs_inst = 32'h80000437;
    i_fs_pc   = 64'h2004;
    repeat (3) begin
      @(negedge i_clk);
      expect_true(o_es_valid && o_es_pc == 64'h2000 && !o_ds_allowin, "first not held");
    end
    i_es_allowin = 1'b1;
    @(negedge i_clk);
    i_fs_valid   = 1'b0;
    i_es_allowin = 1'b0;
    expect_true(o_es_valid && o_es_pc == 64'h2004, "second not taken after release");
    expect_true(o_es_alu_op == rv_pkg::ALU_PASS_IMM, "second decoded wrong");
    i_es_allowin = 1'b1;
    @(negedge i_clk);
    report_test("second offer under back-pressure");

    $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, total_errs);
    if (total_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_gpr_file.sv
hdl/rv_hazard_check.sv
hdl/rv_branch_unit.sv
hdl/rv_id_stage.sv
tb/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_id_stage -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
